/* dv/tb_checker.sv */
module tb_checker (
   input  logic                             ui_clk,
   input  logic                             rst_n,
   input  mem_debug_pkg::wr_data_t          wr_data,
   input  logic                             data_we,
   input  mem_debug_pkg::wr_ctrl_t          wr_ctrl,
   input  logic                             ctrl_we,
   input  logic                             kick,
   input  logic [mem_debug_pkg::num_w-1:0]  read_num,
   input  logic [mem_debug_pkg::addr_w-1:0] read_addr,
   input  logic                             data_full,
   input  logic                             ctrl_full,
   input  logic                             wr_done,
   input  logic                             busy,
   input  logic [mem_debug_pkg::data_w-1:0] buf_dout,
   input  logic                             buf_we,
   input  logic                             done,
   input  int                               exp_reads,
   input  int                               exp_writes,
   output int                               errors,
   output int                               read_count,
   output int                               write_count
);
   timeunit 1ns;
   timeprecision 100ps;

   import mem_debug_pkg::*;

   logic [data_w-1:0] ref_mem [ram_words];
   logic              written [ram_words];
   wr_data_t          data_q [$];
   wr_ctrl_t          ctrl_q [$];
   logic              data_d;
   logic              ctrl_d;
   logic              kick_d;
   logic              data_stb;
   logic              ctrl_stb;
   logic              kick_stb;
   logic [addr_w-1:0] read_ptr;
   int                read_left;
   logic              end_done;
   wr_ctrl_t          cur_ctrl;
   wr_data_t          beat;
   logic [data_w-1:0] exp_word;
   int                idx;

   initial begin
      for (int i = 0; i < ram_words; i++) begin
         written[i] = 1'b0;
      end
   end

   function automatic int word_index(input logic [addr_w-1:0] addr);
      return int'((addr >> 2) % ram_words);
   endfunction

   // Word the RAM should hold after every completed burst
   function automatic logic [data_w-1:0] expected_word(input logic [addr_w-1:0] addr);
      return ref_mem[word_index(addr)];
   endfunction

   task automatic apply_burst();
      int beats;
      beats = int'(cur_ctrl.len) + 1;
      if (data_q.size() < beats) begin
         $display("Error at %0t: burst of %0d beats but only %0d data words queued",
                  $time, beats, data_q.size());
         errors++;
      end else begin
         for (int i = 0; i < beats; i++) begin
            beat = data_q.pop_front();
            idx  = word_index(cur_ctrl.addr + addr_w'(4 * i));
            for (int b = 0; b < strb_w; b++) begin
               if (beat.strb[b]) begin
                  ref_mem[idx][8*b +: 8] = beat.data[8*b +: 8];
               end
            end
            written[idx] = 1'b1;
         end
      end
   endtask

   always @(posedge ui_clk) begin
      if (!rst_n) begin
         data_d      = 1'b0;
         ctrl_d      = 1'b0;
         kick_d      = 1'b0;
         data_stb    = 1'b0;
         ctrl_stb    = 1'b0;
         kick_stb    = 1'b0;
         read_left   = 0;
         read_ptr    = '0;
         end_done    = 1'b0;
         errors      = 0;
         read_count  = 0;
         write_count = 0;
         data_q.delete();
         ctrl_q.delete();
      end else begin
         // Queue flags are only predictable while no burst is open
         if (ctrl_q.size() == 0) begin
            if (data_full !== (data_q.size() == data_depth)) begin
               $display("MISMATCH at %0t: data_full = %b, expected %b",
                        $time, data_full, data_q.size() == data_depth);
               errors++;
            end
            if (ctrl_full !== 1'b0) begin
               $display("MISMATCH at %0t: ctrl_full = %b, expected 0", $time, ctrl_full);
               errors++;
            end
         end
         // Busy drops together with the final buf_we
         if (busy !== (read_left > int'(buf_we))) begin
            $display("MISMATCH at %0t: busy = %b, expected %b",
                     $time, busy, read_left > int'(buf_we));
            errors++;
         end
         if (buf_we) begin
            read_count++;
            if (read_left == 0) begin
               $display("Error at %0t: buf_we with no read outstanding", $time);
               errors++;
            end else begin
               exp_word = expected_word(read_ptr);
               if (!written[word_index(read_ptr)]) begin
                  $display("Error at %0t: read of unwritten address %h", $time, read_ptr);
                  errors++;
               end else if (buf_dout !== exp_word) begin
                  $display("MISMATCH at %0t: buf_dout = %h, expected %h (address %h)",
                           $time, buf_dout, exp_word, read_ptr);
                  errors++;
               end
               read_ptr = read_ptr + addr_w'(4);
               read_left--;
            end
         end
         if (wr_done) begin
            write_count++;
            if (ctrl_q.size() == 0) begin
               $display("Error at %0t: wr_done without a queued control word", $time);
               errors++;
            end else begin
               cur_ctrl = ctrl_q.pop_front();
               apply_burst();
            end
         end
         if (done && !end_done) begin
            end_done = 1'b1;
            if (read_count != exp_reads) begin
               $display("MISMATCH at %0t: buf_we count = %0d, expected %0d",
                        $time, read_count, exp_reads);
               errors++;
            end
            if (write_count != exp_writes) begin
               $display("MISMATCH at %0t: wr_done count = %0d, expected %0d",
                        $time, write_count, exp_writes);
               errors++;
            end
            if (data_q.size() != 0 || ctrl_q.size() != 0) begin
               $display("Error at %0t: write queues not drained at the end", $time);
               errors++;
            end
         end
         // Strobes seen at the last edge act now, as in the DUT
         if (data_stb && data_q.size() < data_depth) begin
            data_q.push_back(wr_data);
         end
         if (ctrl_stb && ctrl_q.size() < ctrl_depth) begin
            ctrl_q.push_back(wr_ctrl);
         end
         if (kick_stb && read_left == 0 && read_num != '0) begin
            read_left = int'(read_num);
            read_ptr  = read_addr;
         end
         data_stb = data_we & ~data_d;
         ctrl_stb = ctrl_we & ~ctrl_d;
         kick_stb = kick & ~kick_d;
         data_d   = data_we;
         ctrl_d   = ctrl_we;
         kick_d   = kick;
      end
   end

endmodule

/* dv/tb_top.sv */
module tb_top;
   timeunit 1ns;
   timeprecision 100ps;

   import mem_debug_pkg::*;

   localparam logic [31:0] lfsr_seed = 32'd29;
   // Taps 32 30 26 25, shifting right
   localparam logic [31:0] lfsr_taps = 32'hA300_0000;
   localparam int reset_cycles = 5;
   localparam int level_cycles = 4;
   localparam int num_levels   = 54;
   localparam int num_reads    = 98;
   localparam int num_writes   = 5;
   localparam int num_phases   = 10;
   localparam int limit_cycles = reset_cycles + level_cycles * num_levels + 2 * num_reads
                                 + 20 * num_phases + 200;
   localparam logic [addr_w-1:0] block_addr = 32'h100;

   logic              ui_clk = 1'b0;
   logic              rst_n;
   wr_data_t          wr_data;
   logic              data_we;
   wr_ctrl_t          wr_ctrl;
   logic              ctrl_we;
   logic              kick;
   logic [num_w-1:0]  read_num;
   logic [addr_w-1:0] read_addr;
   logic              data_full;
   logic              ctrl_full;
   logic              wr_done;
   logic              busy;
   logic [data_w-1:0] buf_dout;
   logic              buf_we;
   logic [31:0]       lfsr;
   int                cycles = 0;
   int                wr_seen = 0;
   int                wr_target;
   logic              done;
   int                errors;
   int                read_count;
   int                write_count;
   logic [addr_w-1:0] rand_addr;
   logic [31:0]       rand_word;

   mem_debug_top UUT (
      .ui_clk    (ui_clk),
      .rst_n     (rst_n),
      .wr_data   (wr_data),
      .data_we   (data_we),
      .wr_ctrl   (wr_ctrl),
      .ctrl_we   (ctrl_we),
      .kick      (kick),
      .read_num  (read_num),
      .read_addr (read_addr),
      .data_full (data_full),
      .ctrl_full (ctrl_full),
      .wr_done   (wr_done),
      .busy      (busy),
      .buf_dout  (buf_dout),
      .buf_we    (buf_we)
   );

   tb_checker u_chk (
      .ui_clk      (ui_clk),
      .rst_n       (rst_n),
      .wr_data     (wr_data),
      .data_we     (data_we),
      .wr_ctrl     (wr_ctrl),
      .ctrl_we     (ctrl_we),
      .kick        (kick),
      .read_num    (read_num),
      .read_addr   (read_addr),
      .data_full   (data_full),
      .ctrl_full   (ctrl_full),
      .wr_done     (wr_done),
      .busy        (busy),
      .buf_dout    (buf_dout),
      .buf_we      (buf_we),
      .done        (done),
      .exp_reads   (num_reads),
      .exp_writes  (num_writes),
      .errors      (errors),
      .read_count  (read_count),
      .write_count (write_count)
   );

   always #5 ui_clk = ~ui_clk;

   always @(posedge ui_clk) begin
      if (rst_n && wr_done) begin
         wr_seen <= wr_seen + 1;
      end
   end

   always @(posedge ui_clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit_cycles) begin
         $display("Timeout: the DUT did not finish within %0d cycles", limit_cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic next_cycle();
      @(posedge ui_clk);
      #1;
   endtask

   task automatic push_data(input logic [data_w-1:0] d, input logic [strb_w-1:0] s);
      wr_data.data = d;
      wr_data.strb = s;
      data_we      = 1'b1;
      repeat (2) next_cycle();
      data_we = 1'b0;
      repeat (2) next_cycle();
   endtask

   task automatic push_ctrl(input logic [len_w-1:0] len, input logic [addr_w-1:0] addr);
      wr_ctrl.len  = len;
      wr_ctrl.addr = addr;
      ctrl_we      = 1'b1;
      repeat (2) next_cycle();
      ctrl_we = 1'b0;
      repeat (2) next_cycle();
   endtask

   task automatic start_read(input logic [num_w-1:0] num, input logic [addr_w-1:0] addr);
      read_num  = num;
      read_addr = addr;
      kick      = 1'b1;
      repeat (2) next_cycle();
      kick = 1'b0;
      repeat (2) next_cycle();
   endtask

   task automatic wait_writes(input int n);
      wr_target = wr_target + n;
      while (wr_seen < wr_target) begin
         next_cycle();
      end
   endtask

   task automatic wait_idle();
      while (busy) begin
         next_cycle();
      end
   endtask

   task automatic read_words(input logic [num_w-1:0] num, input logic [addr_w-1:0] addr);
      start_read(num, addr);
      wait_idle();
   endtask

   // Full-strobe random words, then the control word
   task automatic write_burst(input logic [addr_w-1:0] addr, input int beats);
      logic [31:0] d;
      for (int i = 0; i < beats; i++) begin
         take_bits(32, d);
         push_data(d, 4'hf);
      end
      push_ctrl(len_w'(beats - 1), addr);
      wait_writes(1);
   endtask

   initial begin
      rst_n     = 1'b0;
      wr_data   = '0;
      data_we   = 1'b0;
      wr_ctrl   = '0;
      ctrl_we   = 1'b0;
      kick      = 1'b0;
      read_num  = '0;
      read_addr = '0;
      done      = 1'b0;
      wr_target = 0;
      lfsr      = lfsr_seed;
      repeat (reset_cycles) @(posedge ui_clk);
      #1;
      rst_n = 1'b1;
      repeat (4) next_cycle();

      // Single word away from the block area
      take_bits(8, rand_addr);
      rand_addr = 32'h800 + (rand_addr << 2);
      take_bits(32, rand_word);
      push_data(rand_word, 4'hf);
      push_ctrl('0, rand_addr);
      wait_writes(1);
      read_words(1, rand_addr);

      // Byte lanes 0 and 2 over the same word
      take_bits(32, rand_word);
      push_data(rand_word, 4'b0101);
      push_ctrl('0, rand_addr);
      wait_writes(1);
      read_words(1, rand_addr);

      // Data queue fills before its control word arrives
      write_burst(block_addr, 16);
      read_words(16, block_addr);

      // 40 words read as bursts of 16, 16 and 8
      write_burst(block_addr + 32'h40, 16);
      write_burst(block_addr + 32'h80, 8);
      read_words(40, block_addr);

      // Second kick lands while busy, then a zero count
      start_read(40, block_addr);
      start_read(8, rand_addr);
      wait_idle();
      start_read(0, block_addr);
      repeat (12) next_cycle();

      done = 1'b1;
      repeat (3) next_cycle();
      $display("buf_we: %0d of %0d, wr_done: %0d of %0d, errors: %0d",
               read_count, num_reads, write_count, num_writes, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
hdl/mem_debug_pkg.sv
hdl/sync_fifo.sv
hdl/axi_write_master.sv
hdl/axi_read_master.sv
hdl/axi_slave_ram.sv
hdl/mem_debug_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* hdl/axi_read_master.sv */
module axi_read_master (
   input  logic                                ui_clk,
   input  logic                                rst_n,
   input  logic                                kick,
   input  logic [mem_debug_pkg::num_w-1:0]     read_num,
   input  logic [mem_debug_pkg::addr_w-1:0]    read_addr,
   input  logic                                ar_ready,
   input  logic                                r_valid,
   input  mem_debug_pkg::axi_r_t               r,
   output logic                                busy,
   output mem_debug_pkg::axi_ar_t              ar,
   output logic                                ar_valid,
   output logic [mem_debug_pkg::data_w-1:0]    buf_dout,
   output logic                                buf_we
);

   import mem_debug_pkg::*;

   typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

   state_t            state;
   logic              kick_d;
   logic              kick_stb;
   logic              start;
   logic              ar_fire;
   logic [num_w-1:0]  remain;
   logic [addr_w-1:0] cur_addr;
   logic [num_w-1:0]  burst_beats;

   always_ff @(posedge ui_clk) begin
      if (!rst_n) begin
         kick_d   <= 1'b0;
         kick_stb <= 1'b0;
      end else begin
         kick_d   <= kick;
         kick_stb <= kick & ~kick_d;
      end
   end

   // Kicks during a job or with a zero count are dropped
   assign start   = kick_stb & (state == st_idle) & (read_num != '0);
   assign ar_fire = ar_valid & ar_ready;
   assign busy    = (state != st_idle);

   assign burst_beats = (remain > num_w'(max_burst)) ? num_w'(max_burst) : remain;

   assign ar_valid = (state == st_addr);
   assign ar.addr  = cur_addr;
   assign ar.len   = len_w'(burst_beats - 1'b1);
   assign ar.size  = size_4b;
   assign ar.burst = burst_incr;

   always_ff @(posedge ui_clk) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_addr;
               end
            end
            st_addr: begin
               if (ar_ready) begin
                  state <= st_data;
               end
            end
            default: begin
               if (r_valid && r.last) begin
                  state <= (remain == '0) ? st_idle : st_addr;
               end
            end
         endcase
      end
   end

   // Count and address advance once per accepted burst
   always_ff @(posedge ui_clk) begin
      if (start) begin
         remain   <= read_num;
         cur_addr <= read_addr;
      end else if (ar_fire) begin
         remain   <= remain - burst_beats;
         cur_addr <= cur_addr + (addr_w'(burst_beats) << lsb_w);
      end
   end

   always_ff @(posedge ui_clk) begin
      if (!rst_n) begin
         buf_we <= 1'b0;
      end else begin
         buf_we <= r_valid;
      end
   end

   always_ff @(posedge ui_clk) begin
      buf_dout <= r.data;
   end

endmodule

/* hdl/axi_slave_ram.sv */
module axi_slave_ram (
   input  logic                   ui_clk,
   input  logic                   rst_n,
   input  mem_debug_pkg::axi_aw_t aw,
   input  logic                   aw_valid,
   input  mem_debug_pkg::axi_w_t  w,
   input  logic                   w_valid,
   input  mem_debug_pkg::axi_ar_t ar,
   input  logic                   ar_valid,
   output logic                   aw_ready,
   output logic                   w_ready,
   output mem_debug_pkg::axi_b_t  b,
   output logic                   b_valid,
   output logic                   ar_ready,
   output mem_debug_pkg::axi_r_t  r,
   output logic                   r_valid
);

   import mem_debug_pkg::*;

   typedef enum logic [1:0] {st_idle, st_wdata, st_wresp, st_rdata} state_t;

   state_t            state;
   logic [data_w-1:0] mem [ram_words];
   logic [addr_w-1:0] wr_addr;
   logic [addr_w-1:0] wr_step;
   logic [addr_w-1:0] rd_addr;
   logic [addr_w-1:0] rd_step;
   logic [len_w-1:0]  rd_left;
   logic [data_w-1:0] rd_data;
   logic              aw_fire;
   logic              w_fire;
   logic              ar_fire;

   // Byte step per beat, zero for a fixed burst
   function automatic logic [addr_w-1:0] step_of(input logic [1:0] burst,
                                                 input logic [2:0] size);
      return (burst == burst_incr) ? (addr_w'(1) << size) : '0;
   endfunction

   // Writes take priority when both requests wait
   assign aw_ready = (state == st_idle);
   assign ar_ready = (state == st_idle) & ~aw_valid;
   assign w_ready  = (state == st_wdata);

   assign aw_fire = aw_valid & aw_ready;
   assign ar_fire = ar_valid & ar_ready;
   assign w_fire  = w_valid & w_ready;

   assign b_valid = (state == st_wresp);
   assign b.resp  = resp_okay;

   assign r_valid = (state == st_rdata);
   assign r.data  = rd_data;
   assign r.resp  = resp_okay;
   assign r.last  = (rd_left == '0);

   always_ff @(posedge ui_clk) begin
      if (!rst_n) begin
         state   <= st_idle;
         rd_left <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (aw_fire) begin
                  state <= st_wdata;
               end else if (ar_fire) begin
                  rd_left <= ar.len;
                  state   <= st_rdata;
               end
            end
            st_wdata: begin
               if (w_fire && w.last) begin
                  state <= st_wresp;
               end
            end
            st_wresp: begin
               state <= st_idle;
            end
            default: begin
               rd_left <= rd_left - 1'b1;
               if (rd_left == '0) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge ui_clk) begin
      if (aw_fire) begin
         wr_addr <= aw.addr;
         wr_step <= step_of(aw.burst, aw.size);
      end else if (w_fire) begin
         wr_addr <= wr_addr + wr_step;
      end
   end

   // One word per cycle, first word one cycle after AR
   always_ff @(posedge ui_clk) begin
      if (ar_fire) begin
         rd_data <= mem[ar.addr[lsb_w +: ram_aw]];
         rd_addr <= ar.addr + step_of(ar.burst, ar.size);
         rd_step <= step_of(ar.burst, ar.size);
      end else if (state == st_rdata) begin
         rd_data <= mem[rd_addr[lsb_w +: ram_aw]];
         rd_addr <= rd_addr + rd_step;
      end
   end

   always_ff @(posedge ui_clk) begin
      if (w_fire) begin
         for (int i = 0; i < strb_w; i++) begin
            if (w.strb[i]) begin
               mem[wr_addr[lsb_w +: ram_aw]][8*i +: 8] <= w.data[8*i +: 8];
            end
         end
      end
   end

endmodule

/* hdl/axi_write_master.sv */
module axi_write_master (
   input  logic                    ui_clk,
   input  logic                    rst_n,
   input  mem_debug_pkg::wr_data_t wr_data,
   input  logic                    data_we,
   input  mem_debug_pkg::wr_ctrl_t wr_ctrl,
   input  logic                    ctrl_we,
   input  logic                    aw_ready,
   input  logic                    w_ready,
   input  logic                    b_valid,
   input  mem_debug_pkg::axi_b_t   b,
   output logic                    data_full,
   output logic                    ctrl_full,
   output mem_debug_pkg::axi_aw_t  aw,
   output logic                    aw_valid,
   output mem_debug_pkg::axi_w_t   w,
   output logic                    w_valid,
   output logic                    wr_done
);

   import mem_debug_pkg::*;

   typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} state_t;

   state_t           state;
   logic [1:0]       we_d;
   logic             data_push;
   logic             ctrl_push;
   logic             data_pop;
   logic             ctrl_pop;
   logic             data_empty;
   logic             ctrl_empty;
   wr_data_t         data_head;
   wr_ctrl_t         ctrl_head;
   logic [len_w-1:0] beat_cnt;

   // Host levels to one-cycle strobes
   always_ff @(posedge ui_clk) begin
      if (!rst_n) begin
         we_d      <= '0;
         data_push <= 1'b0;
         ctrl_push <= 1'b0;
      end else begin
         we_d      <= {ctrl_we, data_we};
         data_push <= data_we & ~we_d[0];
         ctrl_push <= ctrl_we & ~we_d[1];
      end
   end

   sync_fifo #(.width($bits(wr_data_t)), .depth(data_depth)) u_data_q (
      .ui_clk    (ui_clk),
      .rst_n     (rst_n),
      .push      (data_push),
      .push_data (wr_data),
      .pop       (data_pop),
      .pop_data  (data_head),
      .full      (data_full),
      .empty     (data_empty)
   );

   sync_fifo #(.width($bits(wr_ctrl_t)), .depth(ctrl_depth)) u_ctrl_q (
      .ui_clk    (ui_clk),
      .rst_n     (rst_n),
      .push      (ctrl_push),
      .push_data (wr_ctrl),
      .pop       (ctrl_pop),
      .pop_data  (ctrl_head),
      .full      (ctrl_full),
      .empty     (ctrl_empty)
   );

   assign ctrl_pop = (state == st_idle) & ~ctrl_empty;
   assign aw_valid = (state == st_addr);
   assign w_valid  = (state == st_data) & ~data_empty;
   assign data_pop = w_valid & w_ready;
   assign w.data   = data_head.data;
   assign w.strb   = data_head.strb;
   assign w.last   = (beat_cnt == aw.len);
   assign wr_done  = (state == st_resp) & b_valid & (b.resp == resp_okay);

   always_ff @(posedge ui_clk) begin
      if (!rst_n) begin
         state    <= st_idle;
         beat_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (ctrl_pop) begin
                  beat_cnt <= '0;
                  state    <= st_addr;
               end
            end
            st_addr: begin
               if (aw_ready) begin
                  state <= st_data;
               end
            end
            st_data: begin
               if (data_pop) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (w.last) begin
                     state <= st_resp;
                  end
               end
            end
            default: begin
               if (b_valid) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   // Burst header taken with the control entry
   always_ff @(posedge ui_clk) begin
      if (ctrl_pop) begin
         aw.addr  <= ctrl_head.addr;
         aw.len   <= ctrl_head.len;
         aw.size  <= size_4b;
         aw.burst <= burst_incr;
      end
   end

endmodule

/* hdl/mem_debug_pkg.sv */
package mem_debug_pkg;

   localparam int addr_w     = 32;
   localparam int data_w     = 32;
   localparam int strb_w     = data_w / 8;
   localparam int len_w      = 8;
   localparam int num_w      = 32;
   localparam int max_burst  = 16;
   localparam int data_depth = 16;
   localparam int ctrl_depth = 4;
   localparam int ram_words  = 1024;
   localparam int ram_aw     = $clog2(ram_words);
   // Byte offset bits below the word index
   localparam int lsb_w      = $clog2(strb_w);

   // AXI encodings
   localparam logic [2:0] size_4b    = 3'b010;
   localparam logic [1:0] burst_incr = 2'b01;
   localparam logic [1:0] resp_okay  = 2'b00;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } wr_data_t;

   // len holds beats minus one
   typedef struct packed {
      logic [len_w-1:0]  len;
      logic [addr_w-1:0] addr;
   } wr_ctrl_t;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [len_w-1:0]  len;
      logic [2:0]        size;
      logic [1:0]        burst;
   } axi_aw_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      logic              last;
   } axi_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } axi_b_t;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [len_w-1:0]  len;
      logic [2:0]        size;
      logic [1:0]        burst;
   } axi_ar_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

endpackage

/* hdl/mem_debug_top.sv */
module mem_debug_top (
   input  logic                             ui_clk,
   input  logic                             rst_n,
   input  mem_debug_pkg::wr_data_t          wr_data,
   input  logic                             data_we,
   input  mem_debug_pkg::wr_ctrl_t          wr_ctrl,
   input  logic                             ctrl_we,
   input  logic                             kick,
   input  logic [mem_debug_pkg::num_w-1:0]  read_num,
   input  logic [mem_debug_pkg::addr_w-1:0] read_addr,
   output logic                             data_full,
   output logic                             ctrl_full,
   output logic                             wr_done,
   output logic                             busy,
   output logic [mem_debug_pkg::data_w-1:0] buf_dout,
   output logic                             buf_we
);

   import mem_debug_pkg::*;

   axi_aw_t aw;
   logic    aw_valid;
   logic    aw_ready;
   axi_w_t  w;
   logic    w_valid;
   logic    w_ready;
   axi_b_t  b;
   logic    b_valid;
   axi_ar_t ar;
   logic    ar_valid;
   logic    ar_ready;
   axi_r_t  r;
   logic    r_valid;

   axi_write_master u_wr (
      .ui_clk    (ui_clk),
      .rst_n     (rst_n),
      .wr_data   (wr_data),
      .data_we   (data_we),
      .wr_ctrl   (wr_ctrl),
      .ctrl_we   (ctrl_we),
      .aw_ready  (aw_ready),
      .w_ready   (w_ready),
      .b_valid   (b_valid),
      .b         (b),
      .data_full (data_full),
      .ctrl_full (ctrl_full),
      .aw        (aw),
      .aw_valid  (aw_valid),
      .w         (w),
      .w_valid   (w_valid),
      .wr_done   (wr_done)
   );

   axi_read_master u_rd (
      .ui_clk    (ui_clk),
      .rst_n     (rst_n),
      .kick      (kick),
      .read_num  (read_num),
      .read_addr (read_addr),
      .ar_ready  (ar_ready),
      .r_valid   (r_valid),
      .r         (r),
      .busy      (busy),
      .ar        (ar),
      .ar_valid  (ar_valid),
      .buf_dout  (buf_dout),
      .buf_we    (buf_we)
   );

   // Stands in for the DDR3 controller
   axi_slave_ram u_ram (
      .ui_clk   (ui_clk),
      .rst_n    (rst_n),
      .aw       (aw),
      .aw_valid (aw_valid),
      .w        (w),
      .w_valid  (w_valid),
      .ar       (ar),
      .ar_valid (ar_valid),
      .aw_ready (aw_ready),
      .w_ready  (w_ready),
      .b        (b),
      .b_valid  (b_valid),
      .ar_ready (ar_ready),
      .r        (r),
      .r_valid  (r_valid)
   );

endmodule

/* hdl/sync_fifo.sv */
module sync_fifo #(
   parameter int width = 8,
   parameter int depth = 4
) (
   input  logic             ui_clk,
   input  logic             rst_n,
   input  logic             push,
   input  logic [width-1:0] push_data,
   input  logic             pop,
   output logic [width-1:0] pop_data,
   output logic             full,
   output logic             empty
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

   logic [width-1:0] mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             do_push;
   logic             do_pop;

   assign full     = (count == (ptr_w + 1)'(depth));
   assign empty    = (count == '0);
   assign do_push  = push & ~full;
   assign do_pop   = pop & ~empty;
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge ui_clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + (ptr_w + 1)'(do_push) - (ptr_w + 1)'(do_pop);
      end
   end

   always_ff @(posedge ui_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the memory debug testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_top -f flist.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
